// File: ins_scan.f
+incdir+source
source/ins_scan_pkg.sv
source/ins_buf_if.sv
source/ins_length_decode.sv
source/ins_class_decode.sv
source/ins_boundary_scan.sv
source/ins_apb_regs.sv
source/ins_scan_top.sv
sim/ins_scan_assert.sv
sim/ins_scan_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the scanner testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f ins_scan.f \
    --top-module ins_scan_tb -o ins_scan_sim; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/ins_scan_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "FAIL: testbench reported an error"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "FAIL: simulator exited with status $status"
  exit 1
fi
echo "PASS"
exit 0

// File: sim/ins_scan_tb.sv
`timescale 1ns/1ns
`include "ins_scan_macros.svh"

module ins_scan_tb;

  // Status polls allowed before a scan counts as hung
  localparam int POLL_LIMIT = 64;

  logic                   clk;
  logic                   arst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`INS_APB_AW-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  // Byte image of the window as loaded into the DUT
  logic [7:0]               win [`INS_WIN_BYTES];
  integer                   seed;
  string                    test_name;
  // Reference model results
  ins_scan_pkg::ins_count_t m_ins;
  ins_scan_pkg::ins_count_t m_br;
  ins_scan_pkg::ins_count_t m_mem;
  ins_scan_pkg::ins_count_t m_pfx;
  ins_scan_pkg::win_ofs_t   m_end;
  logic                     m_ovr;

  ins_scan_top i_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #2 clk = ~clk;

  // ========================================
  // Reporting and compare tasks
  // ========================================

  task automatic stop_sim();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic cmp_count(input string what, input ins_scan_pkg::ins_count_t exp,
                           input ins_scan_pkg::ins_count_t act);
    if (act !== exp) begin
      $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      stop_sim();
    end
  endtask

  task automatic cmp_ofs(input string what, input ins_scan_pkg::win_ofs_t exp,
                         input ins_scan_pkg::win_ofs_t act);
    if (act !== exp) begin
      $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      stop_sim();
    end
  endtask

  task automatic cmp_flag(input string what, input bit exp, input logic act);
    if (act !== exp) begin
      $display("error %s %s: expected %0b, actual %0b", test_name, what, exp, act);
      stop_sim();
    end
  endtask

  // ========================================
  // APB host
  // ========================================

  // Setup edge, access edge, then the bus goes idle again
  task automatic apb_xfer(input logic wr, input logic [`INS_APB_AW-1:0] addr,
                          input logic [31:0] data, input bit exp_err,
                          output logic [31:0] rdata);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    // Response is read at the access edge before any register update lands
    @(posedge clk);
    rdata = prdata;
    cmp_flag("pready", 1'b1, pready);
    cmp_flag("pslverr", exp_err, pslverr);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [`INS_APB_AW-1:0] addr, input logic [31:0] data,
                           input bit exp_err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, exp_err, unused);
  endtask

  task automatic apb_read(input logic [`INS_APB_AW-1:0] addr, input bit exp_err,
                          output logic [31:0] data);
    apb_xfer(1'b0, addr, 32'h0, exp_err, data);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    int          polls;
    polls = 0;
    st    = '0;
    while (st[1] !== 1'b1) begin
      if (polls == POLL_LIMIT) begin
        $display("Test %s: scan never reported done", test_name);
        stop_sim();
      end
      apb_read(`INS_REG_STATUS, 1'b0, st);
      polls++;
    end
  endtask

  // ========================================
  // Reference model
  // ========================================

  function automatic int ref_len(input logic [7:0] op);
    // Branch block 0x20 to 0x3F
    if (op[7:5] == 3'b001) begin
      return 6;
    end
    case (op)
      ins_scan_pkg::BRK, ins_scan_pkg::NOP, ins_scan_pkg::RTS: return 2;
      ins_scan_pkg::PUSH, ins_scan_pkg::POP, ins_scan_pkg::EXI7: return 2;
      ins_scan_pkg::R1, ins_scan_pkg::ADDI, ins_scan_pkg::ANDI: return 4;
      ins_scan_pkg::JEQZ, ins_scan_pkg::LDOS, ins_scan_pkg::STOS: return 4;
      ins_scan_pkg::EXI23: return 4;
      ins_scan_pkg::R2, ins_scan_pkg::ADDIL, ins_scan_pkg::LDO: return 6;
      ins_scan_pkg::STO, ins_scan_pkg::EXI41: return 6;
      ins_scan_pkg::EXI55: return 8;
      default: return 2;
    endcase
  endfunction

  function automatic ins_scan_pkg::ins_class_t ref_cls(input logic [7:0] op);
    if (op[7:5] == 3'b001 || op == ins_scan_pkg::JEQZ) begin
      return ins_scan_pkg::CLS_BRANCH;
    end
    case (op)
      ins_scan_pkg::LDO, ins_scan_pkg::LDOS: return ins_scan_pkg::CLS_MEM;
      ins_scan_pkg::STO, ins_scan_pkg::STOS: return ins_scan_pkg::CLS_MEM;
      ins_scan_pkg::EXI7, ins_scan_pkg::EXI23: return ins_scan_pkg::CLS_PREFIX;
      ins_scan_pkg::EXI41, ins_scan_pkg::EXI55: return ins_scan_pkg::CLS_PREFIX;
      default: return ins_scan_pkg::CLS_OTHER;
    endcase
  endfunction

  // Walks win[] the way the scan is defined and fills the m_ results
  function automatic void model_scan();
    int                       ofs;
    int                       len;
    ins_scan_pkg::ins_class_t cls;
    m_ins = '0;
    m_br  = '0;
    m_mem = '0;
    m_pfx = '0;
    m_ovr = 1'b0;
    ofs   = 0;
    while (ofs < `INS_WIN_BYTES) begin
      len = ref_len(win[ofs]);
      if (ofs + len > `INS_WIN_BYTES) begin
        m_ovr = 1'b1;
        break;
      end
      cls = ref_cls(win[ofs]);
      if (cls == ins_scan_pkg::CLS_PREFIX) begin
        m_pfx++;
      end else begin
        m_ins++;
        if (cls == ins_scan_pkg::CLS_BRANCH) begin
          m_br++;
        end
        if (cls == ins_scan_pkg::CLS_MEM) begin
          m_mem++;
        end
      end
      ofs += len;
    end
    m_end = ins_scan_pkg::win_ofs_t'(ofs);
  endfunction

  // ========================================
  // Window setup and scan checking
  // ========================================

  // Zero operands with n two-byte NOPs from offset 0
  function automatic void fill_nops(input int n);
    for (int i = 0; i < `INS_WIN_BYTES; i++) begin
      win[i] = 8'h00;
    end
    for (int i = 0; i < n; i++) begin
      win[2 * i] = ins_scan_pkg::NOP;
    end
  endfunction

  task automatic load_window();
    for (int w = 0; w < `INS_WIN_WORDS; w++) begin
      apb_write(`INS_APB_AW'(`INS_REG_WIN0 + 4 * w),
                {win[4 * w + 3], win[4 * w + 2], win[4 * w + 1], win[4 * w]}, 1'b0);
    end
  endtask

  task automatic check_scan();
    logic [31:0] cnt;
    logic [31:0] fin;
    logic [31:0] st;
    model_scan();
    apb_read(`INS_REG_COUNTS, 1'b0, cnt);
    apb_read(`INS_REG_END, 1'b0, fin);
    apb_read(`INS_REG_STATUS, 1'b0, st);
    cmp_count("instructions", m_ins, cnt[7:0]);
    cmp_count("branches", m_br, cnt[15:8]);
    cmp_count("memory ops", m_mem, cnt[23:16]);
    cmp_count("prefixes", m_pfx, cnt[31:24]);
    cmp_ofs("end offset", m_end, fin[5:0]);
    cmp_flag("overrun", m_ovr, st[2]);
    cmp_flag("done", 1'b1, st[1]);
    cmp_flag("busy", 1'b0, st[0]);
  endtask

  task automatic run_and_check();
    apb_write(`INS_REG_CTRL, 32'h1, 1'b0);
    wait_done();
    check_scan();
  endtask

  // ========================================
  // Tests
  // ========================================

  task automatic reset_state();
    logic [31:0] st;
    test_name = "reset_state";
    apb_read(`INS_REG_STATUS, 1'b0, st);
    cmp_flag("busy", 1'b0, st[0]);
    cmp_flag("done", 1'b0, st[1]);
    cmp_flag("overrun", 1'b0, st[2]);
    // Nothing is mapped above the last window word
    apb_read(8'h40, 1'b1, st);
  endtask

  task automatic exact_fill();
    test_name = "exact_fill";
    fill_nops(16);
    load_window();
    run_and_check();
  endtask

  task automatic mixed_classes();
    test_name = "mixed_classes";
    fill_nops(0);
    win[0]  = ins_scan_pkg::JEQZ;
    win[4]  = 8'h2C;
    win[10] = ins_scan_pkg::LDO;
    win[16] = ins_scan_pkg::STOS;
    win[20] = ins_scan_pkg::ADDIL;
    win[26] = ins_scan_pkg::EXI23;
    // Unknown opcode, two bytes, closes the window at 32
    win[30] = 8'h77;
    load_window();
    run_and_check();
  endtask

  task automatic overrun_window();
    test_name = "overrun_window";
    fill_nops(14);
    win[28] = ins_scan_pkg::EXI55;
    load_window();
    run_and_check();
  endtask

  task automatic busy_window_write();
    test_name = "busy_window_write";
    fill_nops(16);
    load_window();
    apb_write(`INS_REG_CTRL, 32'h1, 1'b0);
    // Sixteen steps keep the scanner busy well past this write
    // An EXI55 landing at offset 0 would swallow the first four NOPs
    apb_write(`INS_REG_WIN0, 32'h0000_0053, 1'b1);
    wait_done();
    check_scan();
    // A second scan reads word 0 again and must still find the NOP there
    run_and_check();
  endtask

  task automatic random_windows();
    for (int n = 0; n < 20; n++) begin
      test_name = $sformatf("random_window_%0d", n);
      for (int i = 0; i < `INS_WIN_BYTES; i++) begin
        win[i] = 8'($random(seed));
      end
      load_window();
      run_and_check();
    end
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    seed      = 32'hc2e8_2ff4;
    test_name = "startup";
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    reset_state();
    exact_fill();
    mixed_classes();
    overrun_window();
    busy_window_write();
    random_windows();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: sim/ins_scan_assert.sv
`timescale 1ns/1ns

// Protocol and scanner checks attached to the top level
module ins_scan_assert (
  input logic clk,
  input logic arst_n,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic start,
  input logic busy,
  input logic done
);

  // The slave never inserts wait states
  a_pready : assert property (@(posedge clk) disable iff (!arst_n) pready)
    else $error("pready went low");

  // A busy cycle is followed by another step or by done, and never by both
  a_busy_done : assert property (@(posedge clk) disable iff (!arst_n)
                                 busy |=> (busy != done))
    else $error("busy ended without done or overlapped it");

  // An error response belongs to the access phase only
  a_err_phase : assert property (@(posedge clk) disable iff (!arst_n)
                                 pslverr |-> (psel && penable))
    else $error("pslverr raised outside the access phase");

  // Leaving done for a new scan needs a start pulse in the cycle before
  a_restart : assert property (@(posedge clk) disable iff (!arst_n)
                               ($past(done) && busy) |-> $past(start))
    else $error("scan restarted without a start pulse");

endmodule

bind ins_scan_top ins_scan_assert i_assert (
  .clk     (clk),
  .arst_n  (arst_n),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .start   (i_buf.start),
  .busy    (i_buf.busy),
  .done    (i_buf.done)
);

// File: source/ins_scan_top.sv
`timescale 1ns/1ns
`include "ins_scan_macros.svh"

// Instruction boundary scanner with an APB host port
module ins_scan_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`INS_APB_AW-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr
);

  // Opcode under the scan offset and what the two decoders make of it
  ins_scan_pkg::opcode_t    opcode;
  ins_scan_pkg::ins_len_t   len;
  ins_scan_pkg::ins_class_t cls;

  ins_buf_if i_buf ();

  ins_apb_regs i_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .wbuf    (i_buf.regs)
  );

  // Both decoders look at the same byte in parallel
  ins_length_decode i_len (
    .opcode (opcode),
    .len    (len)
  );

  ins_class_decode i_cls (
    .opcode (opcode),
    .cls    (cls)
  );

  ins_boundary_scan i_scan (
    .clk    (clk),
    .arst_n (arst_n),
    .len    (len),
    .cls    (cls),
    .opcode (opcode),
    .wbuf   (i_buf.scan)
  );

endmodule

// File: source/ins_apb_regs.sv
`timescale 1ns/1ns
`include "ins_scan_macros.svh"

// APB slave holding the fetch window and exposing scan control and results
module ins_apb_regs (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`INS_APB_AW-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  ins_buf_if.regs                wbuf
);

  localparam int WIDX_W = $clog2(`INS_WIN_WORDS);

  logic                   access;
  logic                   hit_ctrl;
  logic                   hit_status;
  logic                   hit_counts;
  logic                   hit_end;
  logic                   hit_win;
  logic                   unmapped;
  logic                   err;
  logic                   wr_en;
  logic [`INS_APB_AW-1:0] win_addr;
  logic [WIDX_W-1:0]      win_idx;
  logic [31:0]            win_q [`INS_WIN_WORDS];
  logic [31:0]            rd_word;
  logic                   start_q;

  // ======================================
  // Address decode
  // ======================================

  // No wait states, the access phase always completes
  assign pready = 1'b1;
  assign access = psel & penable;

  assign hit_ctrl   = paddr == `INS_REG_CTRL;
  assign hit_status = paddr == `INS_REG_STATUS;
  assign hit_counts = paddr == `INS_REG_COUNTS;
  assign hit_end    = paddr == `INS_REG_END;
  // Window words must be word aligned
  assign hit_win    = (paddr >= `INS_REG_WIN0) && (paddr <= `INS_REG_WIN_LAST) &&
                      (paddr[1:0] == 2'b00);
  assign unmapped   = !(hit_ctrl || hit_status || hit_counts || hit_end || hit_win);

  assign win_addr = paddr - `INS_REG_WIN0;
  assign win_idx  = win_addr[2 +: WIDX_W];

  // Status, counts and end are read only, the window is locked while scanning
  assign err = access & (unmapped |
                         (pwrite & (hit_status | hit_counts | hit_end)) |
                         (pwrite & hit_win & wbuf.busy));
  assign pslverr = err;

  // A rejected write leaves every register untouched
  assign wr_en = access & pwrite & ~err;

  // ======================================
  // Start pulse and window storage
  // ======================================

  // High for one cycle after the CTRL access edge and dropped while busy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= wr_en & hit_ctrl & pwdata[0] & ~wbuf.busy;
    end
  end

  assign wbuf.start = start_q;

  always_ff @(posedge clk) begin
    if (wr_en && hit_win) begin
      win_q[win_idx] <= pwdata;
    end
  end

  // Little endian byte pick for the scanner read port
  assign rd_word      = win_q[wbuf.rd_ofs[4:2]];
  assign wbuf.rd_byte = rd_word[{wbuf.rd_ofs[1:0], 3'b000} +: 8];

  // ======================================
  // Read data
  // ======================================
  always_comb begin
    prdata = '0;
    if (access && !pwrite && !err) begin
      // CTRL reads back as zero since start clears itself
      if (hit_status) begin
        prdata = {29'd0, wbuf.overrun, wbuf.done, wbuf.busy};
      end else if (hit_counts) begin
        prdata = {wbuf.n_pfx, wbuf.n_mem, wbuf.n_br, wbuf.n_ins};
      end else if (hit_end) begin
        prdata = {26'd0, wbuf.end_ofs};
      end else if (hit_win) begin
        prdata = win_q[win_idx];
      end
    end
  end

endmodule

// File: source/ins_boundary_scan.sv
`timescale 1ns/1ns
`include "ins_scan_macros.svh"

// Walks the fetch window one instruction per clock and tallies results
module ins_boundary_scan (
  input  logic                     clk,
  input  logic                     arst_n,
  input  ins_scan_pkg::ins_len_t   len,
  input  ins_scan_pkg::ins_class_t cls,
  output ins_scan_pkg::opcode_t    opcode,
  ins_buf_if.scan                  wbuf
);

  // Offset one past the last window byte
  localparam ins_scan_pkg::win_ofs_t WIN_END = ins_scan_pkg::win_ofs_t'(`INS_WIN_BYTES);

  ins_scan_pkg::scan_state_t state_q;
  ins_scan_pkg::win_ofs_t    ofs_q;
  ins_scan_pkg::win_ofs_t    next_ofs;
  ins_scan_pkg::win_ofs_t    end_ofs_q;
  ins_scan_pkg::ins_count_t  n_ins_q;
  ins_scan_pkg::ins_count_t  n_br_q;
  ins_scan_pkg::ins_count_t  n_mem_q;
  ins_scan_pkg::ins_count_t  n_pfx_q;
  logic                      overrun_q;
  logic                      past_end;
  logic                      at_end;

  // The byte under the current offset is the opcode for both decoders
  assign wbuf.rd_ofs = ofs_q;
  assign opcode      = ins_scan_pkg::opcode_t'(wbuf.rd_byte);

  // Offset is at most 30 here and len at most 8, so 6 bits never wrap
  assign next_ofs = ofs_q + {2'b00, len};
  assign past_end = next_ofs > WIN_END;
  assign at_end   = next_ofs == WIN_END;

  // ======================================
  // Scan FSM
  // ======================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= ins_scan_pkg::SCAN_IDLE;
      ofs_q     <= '0;
      end_ofs_q <= '0;
      overrun_q <= 1'b0;
      n_ins_q   <= '0;
      n_br_q    <= '0;
      n_mem_q   <= '0;
      n_pfx_q   <= '0;
    end else begin
      case (state_q)
        // A new start clears the previous result, done drops with it
        ins_scan_pkg::SCAN_IDLE, ins_scan_pkg::SCAN_DONE: begin
          if (wbuf.start) begin
            state_q   <= ins_scan_pkg::SCAN_STEP;
            ofs_q     <= '0;
            end_ofs_q <= '0;
            overrun_q <= 1'b0;
            n_ins_q   <= '0;
            n_br_q    <= '0;
            n_mem_q   <= '0;
            n_pfx_q   <= '0;
          end
        end

        ins_scan_pkg::SCAN_STEP: begin
          if (past_end) begin
            // Truncated instruction, report where it began and leave it uncounted
            overrun_q <= 1'b1;
            end_ofs_q <= ofs_q;
            state_q   <= ins_scan_pkg::SCAN_DONE;
          end else begin
            ofs_q     <= next_ofs;
            end_ofs_q <= next_ofs;
            // Prefixes are tallied apart from the instructions they extend
            if (cls == ins_scan_pkg::CLS_PREFIX) begin
              n_pfx_q <= n_pfx_q + 8'd1;
            end else begin
              n_ins_q <= n_ins_q + 8'd1;
              if (cls == ins_scan_pkg::CLS_BRANCH) begin
                n_br_q <= n_br_q + 8'd1;
              end
              if (cls == ins_scan_pkg::CLS_MEM) begin
                n_mem_q <= n_mem_q + 8'd1;
              end
            end
            if (at_end) begin
              state_q <= ins_scan_pkg::SCAN_DONE;
            end
          end
        end

        default: state_q <= ins_scan_pkg::SCAN_IDLE;
      endcase
    end
  end

  // Busy and done come straight from the state so they switch on the same edge
  assign wbuf.busy    = state_q == ins_scan_pkg::SCAN_STEP;
  assign wbuf.done    = state_q == ins_scan_pkg::SCAN_DONE;
  assign wbuf.overrun = overrun_q;
  assign wbuf.end_ofs = end_ofs_q;
  assign wbuf.n_ins   = n_ins_q;
  assign wbuf.n_br    = n_br_q;
  assign wbuf.n_mem   = n_mem_q;
  assign wbuf.n_pfx   = n_pfx_q;

endmodule

// File: source/ins_class_decode.sv
`timescale 1ns/1ns

// Opcode to instruction class lookup
// Runs beside the length decoder on the same opcode byte
module ins_class_decode (
  input  ins_scan_pkg::opcode_t    opcode,
  output ins_scan_pkg::ins_class_t cls
);

  always_comb begin
    casez (opcode)
      // Flow control, the zero test jump plus the branch block
      ins_scan_pkg::JEQZ:  cls = ins_scan_pkg::CLS_BRANCH;
      8'b001?_????:        cls = ins_scan_pkg::CLS_BRANCH;

      // Loads and stores in both long and short displacement forms
      ins_scan_pkg::LDO:   cls = ins_scan_pkg::CLS_MEM;
      ins_scan_pkg::LDOS:  cls = ins_scan_pkg::CLS_MEM;
      ins_scan_pkg::STO:   cls = ins_scan_pkg::CLS_MEM;
      ins_scan_pkg::STOS:  cls = ins_scan_pkg::CLS_MEM;

      // Immediate extension prefixes attach to the following instruction
      ins_scan_pkg::EXI7:  cls = ins_scan_pkg::CLS_PREFIX;
      ins_scan_pkg::EXI23: cls = ins_scan_pkg::CLS_PREFIX;
      ins_scan_pkg::EXI41: cls = ins_scan_pkg::CLS_PREFIX;
      ins_scan_pkg::EXI55: cls = ins_scan_pkg::CLS_PREFIX;

      default:             cls = ins_scan_pkg::CLS_OTHER;
    endcase
  end

endmodule

// File: source/ins_length_decode.sv
`timescale 1ns/1ns

// Opcode to instruction length lookup
// Purely combinational, the scanner samples it in the same cycle
module ins_length_decode (
  input  ins_scan_pkg::opcode_t  opcode,
  output ins_scan_pkg::ins_len_t len
);

  always_comb begin
    casez (opcode)
      // ======================================
      // Two byte forms
      // ======================================
      ins_scan_pkg::BRK:   len = 4'd2;
      ins_scan_pkg::NOP:   len = 4'd2;
      ins_scan_pkg::RTS:   len = 4'd2;
      ins_scan_pkg::PUSH:  len = 4'd2;
      ins_scan_pkg::POP:   len = 4'd2;
      ins_scan_pkg::EXI7:  len = 4'd2;

      // ======================================
      // Four byte forms
      // ======================================
      ins_scan_pkg::R1:    len = 4'd4;
      ins_scan_pkg::ADDI:  len = 4'd4;
      ins_scan_pkg::ANDI:  len = 4'd4;
      ins_scan_pkg::JEQZ:  len = 4'd4;
      // Short memory forms with a small displacement
      ins_scan_pkg::LDOS:  len = 4'd4;
      ins_scan_pkg::STOS:  len = 4'd4;
      ins_scan_pkg::EXI23: len = 4'd4;

      // ======================================
      // Six byte forms
      // ======================================
      ins_scan_pkg::R2:    len = 4'd6;
      ins_scan_pkg::ADDIL: len = 4'd6;
      ins_scan_pkg::LDO:   len = 4'd6;
      ins_scan_pkg::STO:   len = 4'd6;
      ins_scan_pkg::EXI41: len = 4'd6;
      // Conditional branch block covers 0x20 through 0x3F
      8'b001?_????:        len = 4'd6;

      // The widest immediate extension takes a full eight bytes
      ins_scan_pkg::EXI55: len = 4'd8;

      // Opcodes outside the modelled subset are treated as short forms
      default:             len = 4'd2;
    endcase
  end

endmodule

// File: source/ins_buf_if.sv
`timescale 1ns/1ns

// Link between the register block and the boundary scanner
interface ins_buf_if;

  // Start request and window read port, owned by the register block
  logic                    start;
  logic [7:0]              rd_byte;

  // Scanner side: read offset, status and results
  ins_scan_pkg::win_ofs_t   rd_ofs;
  logic                     busy;
  logic                     done;
  logic                     overrun;
  ins_scan_pkg::ins_count_t n_ins;
  ins_scan_pkg::ins_count_t n_br;
  ins_scan_pkg::ins_count_t n_mem;
  ins_scan_pkg::ins_count_t n_pfx;
  ins_scan_pkg::win_ofs_t   end_ofs;

  // Register block view
  modport regs (
    output start, rd_byte,
    input  rd_ofs, busy, done, overrun,
    input  n_ins, n_br, n_mem, n_pfx, end_ofs
  );

  // Scanner view
  modport scan (
    input  start, rd_byte,
    output rd_ofs, busy, done, overrun,
    output n_ins, n_br, n_mem, n_pfx, end_ofs
  );

endinterface

// File: source/ins_scan_pkg.sv
package ins_scan_pkg;

  // ======================================
  // Opcode subset
  // ======================================

  // Only the opcodes the decoders name explicitly are listed here
  // Any other byte value still travels through opcode_t via a cast
  typedef enum logic [7:0] {
    BRK   = 8'h00,
    R1    = 8'h01,
    R2    = 8'h02,
    ADDI  = 8'h04,
    ANDI  = 8'h08,
    ADDIL = 8'h14,
    JEQZ  = 8'h18,
    LDO   = 8'h86,
    LDOS  = 8'h87,
    STO   = 8'h96,
    STOS  = 8'h97,
    EXI7  = 8'h50,
    EXI23 = 8'h51,
    EXI41 = 8'h52,
    EXI55 = 8'h53,
    NOP   = 8'hF1,
    RTS   = 8'hF2,
    PUSH  = 8'hF8,
    POP   = 8'hF9
  } opcode_t;

  // Instruction length in bytes, never more than 8
  typedef logic [3:0] ins_len_t;

  // Coarse instruction class used for the result counters
  typedef enum logic [1:0] {
    CLS_OTHER  = 2'd0,
    CLS_BRANCH = 2'd1,
    CLS_MEM    = 2'd2,
    CLS_PREFIX = 2'd3
  } ins_class_t;

  // Byte offset into the window, one bit wider so it can hold the end offset
  typedef logic [5:0] win_ofs_t;

  typedef logic [7:0] ins_count_t;

  // ======================================
  // Scanner FSM
  // ======================================

  typedef enum logic [1:0] {
    SCAN_IDLE = 2'd0,
    SCAN_STEP = 2'd1,
    SCAN_DONE = 2'd2
  } scan_state_t;

endpackage

// File: source/ins_scan_macros.svh
`ifndef INS_SCAN_MACROS_SVH
`define INS_SCAN_MACROS_SVH

// ======================================
// Fetch window geometry
// ======================================

// Bytes in one fetch window handed to the scanner
`define INS_WIN_BYTES 32
// The window is stored and loaded as 32-bit words
`define INS_WIN_WORDS (`INS_WIN_BYTES / 4)

// ======================================
// APB register map
// ======================================

`define INS_APB_AW 8

`define INS_REG_CTRL   8'h00
`define INS_REG_STATUS 8'h04
`define INS_REG_COUNTS 8'h08
`define INS_REG_END    8'h0C
// First window word, the rest follow at increasing word addresses
`define INS_REG_WIN0   8'h10
`define INS_REG_WIN_LAST (`INS_REG_WIN0 + `INS_WIN_BYTES - 4)

`endif
